//--- src/regexPkg.sv
package regexPkg;

    localparam int CHARACTER_WIDTH = 8;
    localparam int PC_WIDTH = 8;                           // Also the memory address width
    localparam int OPCODE_WIDTH = 3;
    localparam int DATA_WIDTH = 8;                         // Shared by matchChar and targetPc
    localparam int INSTRUCTION_WIDTH = OPCODE_WIDTH + DATA_WIDTH;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        ACCEPT                = 3'd0,                      // Accept only on the terminator
        ACCEPT_PARTIAL        = 3'd1,                      // Accept right away
        SPLIT                 = 3'd2,                      // Fork to pc+1 and target
        MATCH                 = 3'd3,
        MATCH_ANY             = 3'd4,                      // Any non-zero character
        JMP                   = 3'd5,
        END_WITHOUT_ACCEPTING = 3'd6
    } opcode_t;

    // One data word, read as a character by MATCH and as a pc by SPLIT and JMP
    typedef union packed {
        logic [CHARACTER_WIDTH-1:0] matchChar;
        logic [PC_WIDTH-1:0]        targetPc;
    } instrData_t;

    typedef struct packed {
        opcode_t    opcode;
        instrData_t data;
    } instruction_t;

endpackage

//--- src/instrMemory.sv
`timescale 1ns/1ps

module instrMemory
    import regexPkg::*;
(
    input  logic                clk,

    // Program load port
    input  logic                progWrite,
    input  logic [PC_WIDTH-1:0] progAddr,
    input  instruction_t        progData,

    // Fetch port, data follows one cycle after the transfer
    input  logic                memoryValid,
    input  logic [PC_WIDTH-1:0] memoryAddr,
    output logic                memoryReady,
    output instruction_t        memoryData
);
    localparam int DEPTH = 2 ** PC_WIDTH;

    instruction_t programWords [DEPTH];

    assign memoryReady = 1'b1;                             // Single-cycle RAM never stalls

    always_ff @(posedge clk)
    begin
        if (progWrite)
        begin
            programWords[progAddr] <= progData;
        end
    end

    // Registered read
    always_ff @(posedge clk)
    begin
        if (memoryValid && memoryReady)
        begin
            memoryData <= programWords[memoryAddr];
        end
    end

    // Loading and fetching the same word at once gives stale code to the processor
    assert property (@(posedge clk)
        !(progWrite && memoryValid && (progAddr == memoryAddr)))
    else
        $error("instrMemory: write and fetch collide at address %0d", progAddr);

endmodule

//--- src/pcList.sv
`timescale 1ns/1ps

module pcList
    import regexPkg::*;
#(
    parameter int LIST_DEPTH = 16                          // Power of two, 4 or more
)(
    input  logic                clk,
    input  logic                reset,
    input  logic                clear,
    input  logic                push,
    input  logic [PC_WIDTH-1:0] pushPc,
    input  logic                pop,
    output logic [PC_WIDTH-1:0] headPc,
    output logic                empty,
    output logic                full
);
    localparam int PTR_WIDTH = $clog2(LIST_DEPTH);

    logic [PC_WIDTH-1:0]  entries [LIST_DEPTH];
    logic [PTR_WIDTH-1:0] readPtr;
    logic [PTR_WIDTH-1:0] writePtr;
    logic [PTR_WIDTH:0]   count;                           // One extra bit to tell full from empty

    assign headPc = entries[readPtr];                      // Head is visible without a pop
    assign empty  = (count == '0);
    assign full   = (count == (PTR_WIDTH + 1)'(LIST_DEPTH));

    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            readPtr  <= '0;
            writePtr <= '0;
            count    <= '0;
        end
        else
        begin
            if (push)
            begin
                writePtr <= writePtr + 1'b1;               // Wraps since depth is a power of two
            end
            if (pop)
            begin
                readPtr <= readPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            entries[writePtr] <= pushPc;
        end
    end

    // The scheduler must hold back the processor instead of overrunning a list
    assert property (@(posedge clk) disable iff (reset) push |-> !full)
    else
        $error("pcList: push while full");

    assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
    else
        $error("pcList: pop while empty");

endmodule

//--- src/regexCpu.sv
`timescale 1ns/1ps

module regexCpu
    import regexPkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [CHARACTER_WIDTH-1:0] currentCharacter,

    // Thread dispatch in
    input  logic                       inputPcValid,
    input  logic [PC_WIDTH-1:0]        inputPc,
    output logic                       inputPcReady,

    // Instruction fetch
    output logic                       memoryValid,
    output logic [PC_WIDTH-1:0]        memoryAddr,
    input  logic                       memoryReady,
    input  instruction_t               memoryData,

    // Continuation out
    output logic                       outputPcToCurrent,
    output logic                       outputPcValid,
    output logic [PC_WIDTH-1:0]        outputPc,
    input  logic                       outputPcReady,

    output logic                       accepts
);
    localparam logic [2:0] STATE_IDLE       = 3'd0;
    localparam logic [2:0] STATE_FETCH_SEND = 3'd1;
    localparam logic [2:0] STATE_FETCH_REC  = 3'd2;
    localparam logic [2:0] STATE_EXEC_1     = 3'd3;
    localparam logic [2:0] STATE_EXEC_2     = 3'd4;    // Second continuation of a SPLIT

    logic [2:0]          state;
    logic [2:0]          stateNext;
    logic [PC_WIDTH-1:0] currPc;
    instruction_t        currInstr;
    logic                executing;

    // Result of decoding the held instruction
    logic                execValid;
    logic [PC_WIDTH-1:0] execPc;
    logic                execToCurrent;
    logic                execAccepts;
    logic [2:0]          execNextState;

    assign executing = (state == STATE_EXEC_1) || (state == STATE_EXEC_2);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= STATE_IDLE;
        end
        else
        begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == STATE_IDLE && inputPcValid)
        begin
            currPc <= inputPc;
        end
        if (state == STATE_FETCH_REC)
        begin
            currInstr <= memoryData;                   // Read data arrives this cycle
        end
    end

    always_comb
    begin
        execValid     = 1'b0;
        execPc        = currPc + 1'b1;
        execToCurrent = 1'b1;
        execAccepts   = 1'b0;
        execNextState = STATE_IDLE;

        case (currInstr.opcode)
            ACCEPT:
            begin
                execAccepts = (currentCharacter == '0);
            end
            ACCEPT_PARTIAL:
            begin
                execAccepts = 1'b1;
            end
            SPLIT:
            begin
                execValid = 1'b1;
                if (state == STATE_EXEC_1)
                begin
                    execNextState = STATE_EXEC_2;  // Fall-through first, target next
                end
                else
                begin
                    execPc = currInstr.data.targetPc;
                end
            end
            MATCH:
            begin
                execValid     = (currentCharacter == currInstr.data.matchChar);
                execToCurrent = 1'b0;
            end
            MATCH_ANY:
            begin
                execValid     = (currentCharacter != '0); // Never past the terminator
                execToCurrent = 1'b0;
            end
            JMP:
            begin
                execValid = 1'b1;
                execPc    = currInstr.data.targetPc;
            end
            default:
            begin
                execValid = 1'b0;                      // Thread dies
            end
        endcase
    end

    always_comb
    begin
        stateNext         = state;
        inputPcReady      = (state == STATE_IDLE);
        memoryValid       = (state == STATE_FETCH_SEND);
        memoryAddr        = currPc;
        accepts           = executing && execAccepts;
        outputPcValid     = executing && execValid;
        outputPc          = executing ? execPc : '0;
        outputPcToCurrent = executing && execToCurrent;

        case (state)
            STATE_IDLE:
            begin
                if (inputPcValid)
                begin
                    stateNext = STATE_FETCH_SEND;
                end
            end
            STATE_FETCH_SEND:
            begin
                if (memoryReady)
                begin
                    stateNext = STATE_FETCH_REC;
                end
            end
            STATE_FETCH_REC:
            begin
                stateNext = STATE_EXEC_1;
            end
            STATE_EXEC_1, STATE_EXEC_2:
            begin
                if (!execValid || outputPcReady)       // Stay put while stalled
                begin
                    stateNext = execNextState;
                end
            end
            default:
            begin
                stateNext = STATE_IDLE;
            end
        endcase
    end

    // Holds only if the scheduler keeps the character fixed while a thread runs
    assert property (@(posedge clk) disable iff (reset)
        (outputPcValid && !outputPcReady) |=>
            (outputPcValid && $stable(outputPc) && $stable(outputPcToCurrent)))
    else
        $error("regexCpu: continuation changed while stalled");

endmodule

//--- src/threadScheduler.sv
`timescale 1ns/1ps

module threadScheduler
    import regexPkg::*;
#(
    parameter int LIST_DEPTH = 16
)(
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       charValid,
    input  logic [CHARACTER_WIDTH-1:0] charData,
    output logic                       charReady,
    output logic [CHARACTER_WIDTH-1:0] currentCharacter,

    output logic                       inputPcValid,
    output logic [PC_WIDTH-1:0]        inputPc,
    input  logic                       inputPcReady,

    input  logic                       outputPcValid,
    input  logic [PC_WIDTH-1:0]        outputPc,
    input  logic                       outputPcToCurrent,
    output logic                       outputPcReady,

    input  logic                       accepts,
    input  logic                       cpuIdle,
    output logic                       resultValid,
    output logic                       resultMatch
);
    logic                roleBit;                      // Index of the current list
    logic                busy;                         // A string is in progress
    logic                flushing;                     // Clearing lists after reset or a result
    logic                acceptSeen;
    logic                dispatchValid;
    logic [PC_WIDTH-1:0] dispatchPc;

    logic [1:0]          listPush;
    logic [1:0]          listPop;
    logic [1:0]          listEmpty;
    logic [1:0]          listFull;
    logic [PC_WIDTH-1:0] listHead [2];
    logic [PC_WIDTH-1:0] pushPc;

    logic                targetSel;
    logic                cpuTransfer;
    logic                popCurrent;
    logic                seed;
    logic                charTake;
    logic                stepDone;
    logic                startReady;
    logic                finish;

    assign targetSel   = outputPcToCurrent ? roleBit : ~roleBit;
    assign outputPcReady = outputPcValid && !listFull[targetSel];
    assign cpuTransfer = outputPcValid && outputPcReady;

    // Keep one pc waiting in front of the processor
    assign popCurrent = !listEmpty[roleBit] && (!dispatchValid || inputPcReady);

    // Current character is finished when nothing is left to run on it
    assign stepDone   = busy && listEmpty[roleBit] && cpuIdle && !dispatchValid;
    assign startReady = !busy && !flushing && (&listEmpty) && cpuIdle;
    assign charReady  = startReady || (stepDone && (currentCharacter != '0));
    assign finish     = stepDone && (currentCharacter == '0);
    assign charTake   = charValid && charReady;
    assign seed       = charTake && !busy;             // Start thread at pc 0

    assign pushPc      = seed ? '0 : outputPc;
    assign listPush[0] = (cpuTransfer && !targetSel) || (seed && !roleBit);
    assign listPush[1] = (cpuTransfer && targetSel) || (seed && roleBit);
    assign listPop[0]  = popCurrent && !roleBit;
    assign listPop[1]  = popCurrent && roleBit;

    assign inputPcValid = dispatchValid;
    assign inputPc      = dispatchPc;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            roleBit       <= 1'b0;
            busy          <= 1'b0;
            flushing      <= 1'b1;
            acceptSeen    <= 1'b0;
            dispatchValid <= 1'b0;
            resultValid   <= 1'b0;
        end
        else
        begin
            flushing    <= finish;
            resultValid <= finish;
            if (seed)
            begin
                busy <= 1'b1;
            end
            else if (finish)
            begin
                busy <= 1'b0;
            end
            if (seed)
            begin
                acceptSeen <= 1'b0;
            end
            else if (accepts)
            begin
                acceptSeen <= 1'b1;                    // Sticky for the whole string
            end
            if (charTake && busy)
            begin
                roleBit <= ~roleBit;                   // Next list becomes current
            end
            if (popCurrent)
            begin
                dispatchValid <= 1'b1;
            end
            else if (inputPcReady)
            begin
                dispatchValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (charTake)
        begin
            currentCharacter <= charData;
        end
        if (popCurrent)
        begin
            dispatchPc <= listHead[roleBit];
        end
        if (finish)
        begin
            resultMatch <= acceptSeen;
        end
    end

    pcList #(
        .LIST_DEPTH (LIST_DEPTH)
    ) list0 (
        .clk    (clk),
        .reset  (reset),
        .clear  (flushing),
        .push   (listPush[0]),
        .pushPc (pushPc),
        .pop    (listPop[0]),
        .headPc (listHead[0]),
        .empty  (listEmpty[0]),
        .full   (listFull[0])
    );

    pcList #(
        .LIST_DEPTH (LIST_DEPTH)
    ) list1 (
        .clk    (clk),
        .reset  (reset),
        .clear  (flushing),
        .push   (listPush[1]),
        .pushPc (pushPc),
        .pop    (listPop[1]),
        .headPc (listHead[1]),
        .empty  (listEmpty[1]),
        .full   (listFull[1])
    );

endmodule

//--- src/regexEngine.sv
`timescale 1ns/1ps

module regexEngine
    import regexPkg::*;
#(
    parameter int LIST_DEPTH = 16
)(
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       progWrite,
    input  logic [PC_WIDTH-1:0]        progAddr,
    input  instruction_t               progData,

    input  logic                       charValid,
    input  logic [CHARACTER_WIDTH-1:0] charData,
    output logic                       charReady,

    output logic                       resultValid,
    output logic                       resultMatch
);
    logic [CHARACTER_WIDTH-1:0] currentCharacter;
    logic                       inputPcValid;
    logic [PC_WIDTH-1:0]        inputPc;
    logic                       inputPcReady;          // Also tells the scheduler the cpu is idle
    logic                       memoryValid;
    logic [PC_WIDTH-1:0]        memoryAddr;
    logic                       memoryReady;
    instruction_t               memoryData;
    logic                       outputPcValid;
    logic [PC_WIDTH-1:0]        outputPc;
    logic                       outputPcToCurrent;
    logic                       outputPcReady;
    logic                       accepts;

    instrMemory memory (
        .clk         (clk),
        .progWrite   (progWrite),
        .progAddr    (progAddr),
        .progData    (progData),
        .memoryValid (memoryValid),
        .memoryAddr  (memoryAddr),
        .memoryReady (memoryReady),
        .memoryData  (memoryData)
    );

    threadScheduler #(
        .LIST_DEPTH (LIST_DEPTH)
    ) scheduler (
        .clk               (clk),
        .reset             (reset),
        .charValid         (charValid),
        .charData          (charData),
        .charReady         (charReady),
        .currentCharacter  (currentCharacter),
        .inputPcValid      (inputPcValid),
        .inputPc           (inputPc),
        .inputPcReady      (inputPcReady),
        .outputPcValid     (outputPcValid),
        .outputPc          (outputPc),
        .outputPcToCurrent (outputPcToCurrent),
        .outputPcReady     (outputPcReady),
        .accepts           (accepts),
        .cpuIdle           (inputPcReady),
        .resultValid       (resultValid),
        .resultMatch       (resultMatch)
    );

    regexCpu cpu (
        .clk               (clk),
        .reset             (reset),
        .currentCharacter  (currentCharacter),
        .inputPcValid      (inputPcValid),
        .inputPc           (inputPc),
        .inputPcReady      (inputPcReady),
        .memoryValid       (memoryValid),
        .memoryAddr        (memoryAddr),
        .memoryReady       (memoryReady),
        .memoryData        (memoryData),
        .outputPcToCurrent (outputPcToCurrent),
        .outputPcValid     (outputPcValid),
        .outputPc          (outputPc),
        .outputPcReady     (outputPcReady),
        .accepts           (accepts)
    );

endmodule

//--- sim/regexPrograms.svh
`ifndef REGEX_PROGRAMS_SVH
`define REGEX_PROGRAMS_SVH

localparam int PROGRAM_COUNT  = 5;
localparam int PROGRAM_LENGTH = 8;                         // Words loaded per program
localparam int TEXT_LENGTH    = 8;                         // Characters per test string at most
localparam int TEST_COUNT     = 13;

typedef logic [CHARACTER_WIDTH*TEXT_LENGTH-1:0] text_t;   // Right aligned, zero padded

localparam logic [INSTRUCTION_WIDTH-1:0] DEAD_END = {END_WITHOUT_ACCEPTING, 8'h00};

// Every program starts at pc 0, unused words kill the thread
localparam logic [INSTRUCTION_WIDTH-1:0] PROGRAMS [PROGRAM_COUNT][PROGRAM_LENGTH] = '{
    // abc
    '{{MATCH, "a"}, {MATCH, "b"}, {MATCH, "c"}, {ACCEPT, 8'h00},
      DEAD_END, DEAD_END, DEAD_END, DEAD_END},
    // a.c
    '{{MATCH, "a"}, {MATCH_ANY, 8'h00}, {MATCH, "c"}, {ACCEPT, 8'h00},
      DEAD_END, DEAD_END, DEAD_END, DEAD_END},
    // (a|b)c
    '{{SPLIT, 8'd3}, {MATCH, "a"}, {JMP, 8'd4}, {MATCH, "b"},
      {MATCH, "c"}, {ACCEPT, 8'h00}, DEAD_END, DEAD_END},
    // ab followed by anything
    '{{MATCH, "a"}, {MATCH, "b"}, {ACCEPT_PARTIAL, 8'h00}, DEAD_END,
      DEAD_END, DEAD_END, DEAD_END, DEAD_END},
    // a*b, the loop always consumes before jumping back
    '{{SPLIT, 8'd3}, {MATCH, "a"}, {JMP, 8'd0}, {MATCH, "b"},
      {ACCEPT, 8'h00}, DEAD_END, DEAD_END, DEAD_END}
};

typedef struct packed {
    int    programIndex;
    text_t text;
    logic  expectMatch;
} testCase_t;

// Tests sharing a program stay next to each other so it is loaded once
localparam testCase_t TESTS [TEST_COUNT] = '{
    '{0, text_t'("abc"),   1'b1},
    '{0, text_t'("abd"),   1'b0},
    '{0, text_t'("ab"),    1'b0},                        // Runs out before c
    '{1, text_t'("axc"),   1'b1},
    '{1, text_t'("ac"),    1'b0},
    '{2, text_t'("ac"),    1'b1},
    '{2, text_t'("bc"),    1'b1},
    '{2, text_t'("cc"),    1'b0},
    '{3, text_t'("abzzz"), 1'b1},                        // Prefix accept
    '{3, text_t'("azzz"),  1'b0},
    '{4, text_t'("aaaab"), 1'b1},
    '{4, text_t'("b"),     1'b1},
    '{4, text_t'("aaac"),  1'b0}
};

`endif

//--- sim/regexEngineTb.sv
`timescale 1ns/1ps

module regexEngineTb
    import regexPkg::*;
();
    localparam int LIST_DEPTH     = 4;                     // Smallest legal lists
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = 2000;

    `include "regexPrograms.svh"

    logic                       clk = 1'b0;
    logic                       reset = 1'b1;
    logic                       progWrite;
    logic [PC_WIDTH-1:0]        progAddr;
    instruction_t               progData;
    logic                       charValid;
    logic [CHARACTER_WIDTH-1:0] charData;
    logic                       charReady;
    logic                       resultValid;
    logic                       resultMatch;

    logic resetHeld = 1'b0;                                // Reset seen on the previous edge
    logic awaitingResult;
    logic expectedMatch;
    int   currentTest = 0;
    int   assertErrors = 0;
    int   timeoutErrors = 0;
    int   checkedStrings = 0;

    always #5 clk = ~clk;

    always @(posedge clk) resetHeld <= reset;

    regexEngine #(
        .LIST_DEPTH (LIST_DEPTH)
    ) i_regexEngine (
        .clk         (clk),
        .reset       (reset),
        .progWrite   (progWrite),
        .progAddr    (progAddr),
        .progData    (progData),
        .charValid   (charValid),
        .charData    (charData),
        .charReady   (charReady),
        .resultValid (resultValid),
        .resultMatch (resultMatch)
    );

    // Nothing may be offered or reported once reset has taken hold
    assert property (@(posedge clk) (reset && resetHeld) |-> (!charReady && !resultValid))
    else
    begin
        assertErrors = assertErrors + 1;
        $display("error %0t: charReady or resultValid high during reset", $time);
    end

    assert property (@(posedge clk) resultValid |-> awaitingResult)
    else
    begin
        assertErrors = assertErrors + 1;
        $display("error %0t: result pulse with no string outstanding", $time);
    end

    assert property (@(posedge clk) resultValid |-> (resultMatch == expectedMatch))
    else
    begin
        assertErrors = assertErrors + 1;
        $display("error %0t: string %0d gave match %0b, expected %0b",
                 $time, currentTest, resultMatch, expectedMatch);
    end

    task automatic loadProgram(input int index);
        for (int addr = 0; addr < PROGRAM_LENGTH; addr++)
        begin
            @(negedge clk);
            progWrite = 1'b1;
            progAddr  = PC_WIDTH'(addr);
            progData  = instruction_t'(PROGRAMS[index][addr]);
        end
        @(negedge clk);
        progWrite = 1'b0;
    endtask

    task automatic sendCharacter(input logic [CHARACTER_WIDTH-1:0] character);
        int gap;
        int waitCycles;
        begin
            gap = $urandom % 3;                            // Random idle cycles on the stream
            waitCycles = 0;
            repeat (gap) @(negedge clk);
            @(negedge clk);
            charValid = 1'b1;
            charData  = character;
            // charReady does not depend on charValid, so it is settled here
            while (!charReady && waitCycles < TIMEOUT_CYCLES)
            begin
                @(negedge clk);
                waitCycles++;
            end
            if (!charReady)
            begin
                timeoutErrors++;
                $display("Timeout: character %0h was never accepted", character);
            end
            @(negedge clk);                                // Transfer happened on the last rise
            charValid = 1'b0;
        end
    endtask

    task automatic runString(input int index);
        logic [CHARACTER_WIDTH-1:0] character;
        int waitCycles;
        begin
            currentTest    = index;
            expectedMatch  = TESTS[index].expectMatch;
            awaitingResult = 1'b1;
            for (int pos = TEXT_LENGTH - 1; pos >= 0 && timeoutErrors == 0; pos--)
            begin
                character = TESTS[index].text[pos*CHARACTER_WIDTH +: CHARACTER_WIDTH];
                if (character != '0)
                    sendCharacter(character);
            end
            if (timeoutErrors == 0)
                sendCharacter('0);                         // Terminator
            waitCycles = 0;
            while (timeoutErrors == 0 && !resultValid && waitCycles < TIMEOUT_CYCLES)
            begin
                @(negedge clk);
                waitCycles++;
            end
            if (resultValid)
                checkedStrings++;
            else if (timeoutErrors == 0)
            begin
                timeoutErrors++;
                $display("Timeout: no result for string %0d within %0d cycles",
                         index, TIMEOUT_CYCLES);
            end
            @(negedge clk);
            awaitingResult = 1'b0;
        end
    endtask

    initial
    begin
        int loadedProgram;

        void'($urandom(32'h4b3d));
        loadedProgram  = -1;
        progWrite      = 1'b0;
        progAddr       = '0;
        progData       = '0;
        charValid      = 1'b0;
        charData       = '0;
        awaitingResult = 1'b0;
        expectedMatch  = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int t = 0; t < TEST_COUNT && timeoutErrors == 0; t++)
        begin
            if (TESTS[t].programIndex != loadedProgram)
            begin
                loadProgram(TESTS[t].programIndex);
                loadedProgram = TESTS[t].programIndex;
            end
            runString(t);
        end

        $display("Strings checked: %0d of %0d, assertion errors: %0d, timeouts: %0d",
                 checkedStrings, TEST_COUNT, assertErrors, timeoutErrors);
        if (assertErrors == 0 && timeoutErrors == 0 && checkedStrings == TEST_COUNT)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- regexEngine.f
+incdir+sim
src/regexPkg.sv
src/instrMemory.sv
src/pcList.sv
src/regexCpu.sv
src/threadScheduler.sv
src/regexEngine.sv
sim/regexEngineTb.sv

//--- Makefile
# Verilator build and run of the regex engine testbench

VERILATOR  ?= verilator
TOP        ?= regexEngineTb
LINT_TOP   ?= regexEngine
FILE_LIST  ?= regexEngine.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT  ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: build
	@output="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qxF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)
